// ==== wresp_bank.f ====
+incdir+design
design/wresp_pkg.sv
design/wresp_link_if.sv
design/wresp_slot_alloc.sv
design/wresp_msg_store.sv
design/wresp_release_pick.sv
design/wresp_bank_ctrl.sv
design/wresp_bank_top.sv
verif/wresp_bank_asserts.sv
verif/wresp_bank_tb.sv

// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --assert -j 0
TOP   = wresp_bank_tb
FLIST = wresp_bank.f
LOG   = sim.log

SRCS  = $(wildcard design/*.sv design/*.svh verif/*.sv)
BIN   = obj_dir/V$(TOP)

.PHONY: all run check clean

all: check

obj_dir/V%: $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $* -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/wresp_bank_tb.sv ====
// Randomized testbench with a cycle model of the bank; stimulus assumes 32-bit messages
// Inputs change 2 ns after the rising edge, outputs are compared at the falling edge
`timescale 1ns/100ps
`default_nettype none

`include "wresp_config.svh"

module wresp_bank_tb;

  localparam int DRAIN_LIMIT = 200;

  logic                    clk_i;
  logic                    rst_ni;
  wresp_pkg::id_t          res_id_i;
  logic                    res_ready_i;
  logic                    res_valid_o;
  wresp_pkg::slot_addr_t   res_addr_o;
  logic [`WRESP_MSG_W-1:0] in_data_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  logic [`WRESP_MSG_W-1:0] out_data_o;
  logic                    out_valid_o;
  logic                    out_ready_i;
  wresp_pkg::slot_vec_t    release_en_i;
  wresp_pkg::slot_vec_t    released_onehot_o;

  // Model state, updated at each falling edge to the state after the next rising edge
  wresp_pkg::slot_vec_t    m_occ;
  wresp_pkg::slot_addr_t   res_q [`WRESP_NUM_IDS][$];
  wresp_pkg::slot_addr_t   fill_q [`WRESP_NUM_IDS][$];
  logic [`WRESP_MSG_W-1:0] slot_data [`WRESP_CAPACITY];
  logic                    m_out_valid;
  logic [`WRESP_MSG_W-1:0] m_out_data;
  wresp_pkg::slot_addr_t   m_out_slot;
  logic                    exp_res_valid;
  wresp_pkg::slot_addr_t   exp_res_addr;
  logic                    exp_in_ready;
  wresp_pkg::slot_vec_t    exp_released;

  logic [31:0]             lcg_state;
  logic [15:0]             seq;
  logic                    checking;
  logic                    aborted;
  logic [31:0]             r;
  int                      test_checks;
  int                      test_errors;
  int                      total_checks;
  int                      total_errors;

  wresp_bank_top dut0 (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .res_id_i          (res_id_i),
    .res_ready_i       (res_ready_i),
    .res_valid_o       (res_valid_o),
    .res_addr_o        (res_addr_o),
    .in_data_i         (in_data_i),
    .in_valid_i        (in_valid_i),
    .in_ready_o        (in_ready_o),
    .out_data_o        (out_data_o),
    .out_valid_o       (out_valid_o),
    .out_ready_i       (out_ready_i),
    .release_en_i      (release_en_i),
    .released_onehot_o (released_onehot_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic wresp_pkg::slot_addr_t lowest_free();
    for (int i = 0; i < `WRESP_CAPACITY; i++) begin
      if (!m_occ[i]) begin
        return wresp_pkg::slot_addr_t'(i);
      end
    end
    return '0;
  endfunction

  // First identifier from start upwards that still has a reserved, unfilled slot
  function automatic logic reserved_id(input wresp_pkg::id_t start, output wresp_pkg::id_t id);
    id = start;
    for (int k = 0; k < `WRESP_NUM_IDS; k++) begin
      id = start + wresp_pkg::id_t'(k);
      if (res_q[id].size() != 0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Reference model: expected handshakes for the current inputs, then the next state
  function automatic void model_cycle();
    wresp_pkg::slot_addr_t low;
    wresp_pkg::slot_addr_t slot;
    wresp_pkg::id_t        in_id;
    wresp_pkg::id_t        pick_id;
    logic                  pick_valid;
    logic                  out_hs;
    low           = lowest_free();
    in_id         = in_data_i[`WRESP_ID_W-1:0];
    exp_res_valid = (m_occ != '1);
    exp_res_addr  = low;
    exp_in_ready  = in_valid_i && (res_q[in_id].size() != 0);
    out_hs        = m_out_valid && out_ready_i;
    exp_released  = out_hs ? (wresp_pkg::slot_vec_t'(1) << m_out_slot) : '0;
    // Lowest identifier whose oldest stored message is enabled
    pick_valid = 1'b0;
    pick_id    = '0;
    for (int i = 0; i < `WRESP_NUM_IDS && !pick_valid; i++) begin
      if (fill_q[i].size() != 0 && release_en_i[fill_q[i][0]]) begin
        pick_valid = 1'b1;
        pick_id    = wresp_pkg::id_t'(i);
      end
    end
    if (out_hs) begin
      m_occ[m_out_slot] = 1'b0;
      m_out_valid       = 1'b0;
    end
    if (pick_valid && (!m_out_valid || out_ready_i)) begin
      m_out_slot  = fill_q[pick_id].pop_front();
      m_out_data  = slot_data[m_out_slot];
      m_out_valid = 1'b1;
    end
    if (exp_in_ready) begin
      slot            = res_q[in_id].pop_front();
      slot_data[slot] = in_data_i;
      fill_q[in_id].push_back(slot);
    end
    if (exp_res_valid && res_ready_i) begin
      m_occ[low] = 1'b1;
      res_q[res_id_i].push_back(low);
    end
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  always @(negedge clk_i) begin
    if (checking) begin
      check("out_valid_o", 32'(out_valid_o), 32'(m_out_valid));
      if (m_out_valid) begin
        check("out_data_o", 32'(out_data_o), 32'(m_out_data));
      end
      model_cycle();
      check("res_valid_o", 32'(res_valid_o), 32'(exp_res_valid));
      if (exp_res_valid) begin
        check("res_addr_o", 32'(res_addr_o), 32'(exp_res_addr));
      end
      check("in_ready_o", 32'(in_ready_o), 32'(exp_in_ready));
      check("released_onehot_o", 32'(released_onehot_o), 32'(exp_released));
    end
  end

  task automatic end_test(input string name);
    $display("Test %-16s %0d checks, %0d errors", name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  // Weights are out of 16; a message goes to a reserved identifier about half the time
  task automatic drive_random(input logic [3:0] res_w, input logic [3:0] rdy_w,
                              input wresp_pkg::slot_vec_t rel);
    logic [31:0]    v;
    wresp_pkg::id_t id;
    v = next_rand();
    res_ready_i  = (v[3:0] < res_w);
    res_id_i     = {1'b0, v[6:4]};
    out_ready_i  = (v[11:8] < rdy_w);
    in_valid_i   = (v[15:12] < 4'd12);
    release_en_i = rel;
    v = next_rand();
    if (!(v[16] && reserved_id(v[3:0], id))) begin
      id = {1'b0, v[6:4]};
    end
    seq++;
    in_data_i = {v[31:20], seq, id};
  endtask

  // Fill every reserved slot and release everything until the bank is empty
  task automatic drain(input string name);
    logic           done;
    logic [31:0]    v;
    wresp_pkg::id_t id;
    int             n;
    done = 1'b0;
    n    = 0;
    while (!done && n < DRAIN_LIMIT) begin
      @(posedge clk_i);
      #2;
      res_ready_i  = 1'b0;
      out_ready_i  = 1'b1;
      release_en_i = '1;
      v            = next_rand();
      done         = (m_occ == '0) && !m_out_valid;
      in_valid_i   = !done && reserved_id(v[3:0], id);
      seq++;
      in_data_i    = {v[31:20], seq, id};
      n++;
    end
    in_valid_i = 1'b0;
    if (!done) begin
      $display("Timeout: bank still holds slots after %0d drain cycles in %s", n, name);
      test_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic run_traffic(input string name, input int cycles, input logic [3:0] res_w,
                             input logic [3:0] rdy_w, input wresp_pkg::slot_vec_t rel);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk_i);
      #2;
      drive_random(res_w, rdy_w, rel);
    end
    drain(name);
    end_test(name);
  endtask

  initial begin
    rst_ni       = 1'b0;
    res_id_i     = '0;
    res_ready_i  = 1'b0;
    in_data_i    = '0;
    in_valid_i   = 1'b0;
    out_ready_i  = 1'b0;
    release_en_i = '1;
    m_occ        = '0;
    m_out_valid  = 1'b0;
    m_out_data   = '0;
    m_out_slot   = '0;
    lcg_state    = 32'h71dc;
    seq          = '0;
    checking     = 1'b0;
    aborted      = 1'b0;
    test_checks  = 0;
    test_errors  = 0;
    total_checks = 0;
    total_errors = 0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni   = 1'b1;
    checking = 1'b1;

    @(negedge clk_i);
    check("out_valid_o after reset", 32'(out_valid_o), 32'd0);
    check("in_ready_o after reset", 32'(in_ready_o), 32'd0);
    check("released_onehot_o after reset", 32'(released_onehot_o), 32'd0);
    check("res_valid_o after reset", 32'(res_valid_o), 32'd1);
    check("res_addr_o after reset", 32'(res_addr_o), 32'd0);
    #1;
    end_test("reset");

    // Reserve every slot with no traffic, the pool must report full
    for (int i = 0; i < `WRESP_CAPACITY; i++) begin
      @(posedge clk_i);
      #2;
      r           = next_rand();
      res_ready_i = 1'b1;
      res_id_i    = r[3:0];
    end
    @(posedge clk_i);
    #2;
    res_ready_i = 1'b0;
    @(negedge clk_i);
    check("res_valid_o with all slots reserved", 32'(res_valid_o), 32'd0);
    drain("reservation");
    end_test("reservation");

    if (!aborted) begin
      run_traffic("ordered_release", 400, 4'd8, 4'd12, '1);
    end
    if (!aborted) begin
      r = next_rand();
      run_traffic("release_gating", 300, 4'd8, 4'd12, r[15:0]);
    end
    if (!aborted) begin
      run_traffic("back_pressure", 300, 4'd8, 4'd3, '1);
    end

    checking = 1'b0;
    $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/wresp_bank_asserts.sv ====
// Port-level protocol assertions, bound to the bank top level
// Checked only while reset is released
`timescale 1ns/100ps
`default_nettype none

`include "wresp_config.svh"

module wresp_bank_asserts (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       out_valid_o,
  input logic                       out_ready_i,
  input logic [`WRESP_MSG_W-1:0]    out_data_o,
  input logic [`WRESP_CAPACITY-1:0] released_onehot_o
);

  // Output register holds while the consumer stalls
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
    else $error("Output message changed while stalled");

  a_rel_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(released_onehot_o))
    else $error("More than one slot released in a cycle");

  // Slots are only released by an output handshake
  a_rel_hs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (released_onehot_o != '0) |-> (out_valid_o && out_ready_i))
    else $error("Slot released without an output handshake");

endmodule

bind wresp_bank_top wresp_bank_asserts asserts0 (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .out_valid_o       (out_valid_o),
  .out_ready_i       (out_ready_i),
  .out_data_o        (out_data_o),
  .released_onehot_o (released_onehot_o)
);

`default_nettype wire

// ==== design/wresp_bank_top.sv ====
// Write-response bank with per-identifier ordering over one shared slot pool
// Sizes are fixed by the config macros; in_ready_o depends on in_valid_i
`timescale 1ns/100ps
`default_nettype none

`include "wresp_config.svh"

module wresp_bank_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Reservation
  input  logic [`WRESP_ID_W-1:0]     res_id_i,
  input  logic                      res_ready_i,
  output logic                      res_valid_o,
  output logic [`WRESP_ADDR_W-1:0]   res_addr_o,

  // Message input
  input  logic [`WRESP_MSG_W-1:0]    in_data_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,

  // Message output
  output logic [`WRESP_MSG_W-1:0]    out_data_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,

  // Release gating and freed slot
  input  logic [`WRESP_CAPACITY-1:0] release_en_i,
  output logic [`WRESP_CAPACITY-1:0] released_onehot_o
);

  logic                                        any_free;
  logic                                        occupy;
  wresp_pkg::slot_addr_t                       occupy_addr;
  wresp_pkg::slot_addr_t [`WRESP_NUM_IDS-1:0]  tails;
  wresp_pkg::id_vec_t                          nonempty;
  logic                                        pick_valid;
  wresp_pkg::id_t                              pick_id;
  wresp_pkg::slot_addr_t                       pick_addr;

  wresp_link_if link_bus ();

  wresp_bank_ctrl ctrl0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .res_id_i      (res_id_i),
    .res_ready_i   (res_ready_i),
    .res_valid_o   (res_valid_o),
    .in_data_i     (in_data_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .out_data_o    (out_data_o),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .free_addr_i   (res_addr_o),
    .any_free_i    (any_free),
    .occupy_o      (occupy),
    .occupy_addr_o (occupy_addr),
    .free_onehot_o (released_onehot_o),
    .tails_o       (tails),
    .nonempty_o    (nonempty),
    .pick_valid_i  (pick_valid),
    .pick_id_i     (pick_id),
    .pick_addr_i   (pick_addr),
    .link          (link_bus.ctrl)
  );

  wresp_slot_alloc alloc0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .occupy_i      (occupy),
    .occupy_addr_i (occupy_addr),
    .free_onehot_i (released_onehot_o),
    .free_addr_o   (res_addr_o),
    .any_free_o    (any_free)
  );

  wresp_msg_store store0 (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .link   (link_bus.store)
  );

  wresp_release_pick pick0 (
    .tails_i      (tails),
    .nonempty_i   (nonempty),
    .release_en_i (release_en_i),
    .pick_valid_o (pick_valid),
    .pick_id_o    (pick_id),
    .pick_addr_o  (pick_addr)
  );

endmodule

`default_nettype wire

// ==== design/wresp_bank_ctrl.sv ====
// Per-identifier list state and all handshake decisions
// A message is only accepted for an identifier with a reserved, unfilled slot
`timescale 1ns/100ps
`default_nettype none

`include "wresp_config.svh"

module wresp_bank_ctrl (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  wresp_pkg::id_t                             res_id_i,
  input  logic                                       res_ready_i,
  output logic                                       res_valid_o,
  input  wresp_pkg::msg_u                            in_data_i,
  input  logic                                       in_valid_i,
  output logic                                       in_ready_o,
  output wresp_pkg::msg_u                            out_data_o,
  output logic                                       out_valid_o,
  input  logic                                       out_ready_i,
  input  wresp_pkg::slot_addr_t                      free_addr_i,
  input  logic                                       any_free_i,
  output logic                                       occupy_o,
  output wresp_pkg::slot_addr_t                      occupy_addr_o,
  output wresp_pkg::slot_vec_t                       free_onehot_o,
  output wresp_pkg::slot_addr_t [`WRESP_NUM_IDS-1:0] tails_o,
  output wresp_pkg::id_vec_t                         nonempty_o,
  input  logic                                       pick_valid_i,
  input  wresp_pkg::id_t                             pick_id_i,
  input  wresp_pkg::slot_addr_t                      pick_addr_i,
  wresp_link_if.ctrl                                 link
);

  // Counts reach the full capacity, so one extra bit
  typedef logic [`WRESP_ADDR_W:0] cnt_t;

  wresp_pkg::id_t                              in_id;
  logic                                        res_hs;
  logic                                        in_hs;
  logic                                        out_hs;
  logic                                        load;
  wresp_pkg::slot_addr_t [`WRESP_NUM_IDS-1:0]  res_tails;
  wresp_pkg::slot_addr_t [`WRESP_NUM_IDS-1:0]  fill_heads;
  wresp_pkg::id_vec_t                          has_reserved;
  wresp_pkg::id_vec_t                          list_empty;

  logic                  out_valid_q;
  wresp_pkg::msg_u       out_data_q;
  wresp_pkg::slot_addr_t out_addr_q;

  assign in_id = in_data_i.f.id;

  // Handshakes
  assign res_valid_o = any_free_i;
  assign res_hs      = any_free_i & res_ready_i;
  assign in_ready_o  = in_valid_i & has_reserved[in_id];
  assign in_hs       = in_valid_i & in_ready_o;
  assign out_hs      = out_valid_q & out_ready_i;
  // Output register takes a new message when empty or draining
  assign load        = pick_valid_i & (~out_valid_q | out_ready_i);

  assign occupy_o      = res_hs;
  assign occupy_addr_o = free_addr_i;

  // Fill goes to the identifier's fill head, read-out comes from the picked tail
  assign link.msg_we       = in_hs;
  assign link.msg_waddr    = fill_heads[in_id];
  assign link.msg_wdata    = in_data_i;
  assign link.msg_raddr    = pick_addr_i;
  assign link.link_raddr_a = fill_heads[in_id];
  assign link.link_raddr_b = pick_addr_i;

  // Chain a new reservation behind the last one, unless the list is empty
  assign link.link_we    = res_hs & ~list_empty[res_id_i];
  assign link.link_waddr = res_tails[res_id_i];
  assign link.link_wdata = free_addr_i;

  for (genvar g = 0; g < `WRESP_NUM_IDS; g++) begin : g_id
    logic                  res_hit;
    logic                  fill_hit;
    logic                  load_hit;
    logic                  drains;
    wresp_pkg::slot_addr_t res_tail_q;
    wresp_pkg::slot_addr_t fill_head_q;
    wresp_pkg::slot_addr_t tail_q;
    cnt_t                  res_cnt_q;
    cnt_t                  fill_cnt_q;

    assign res_hit  = res_hs & (res_id_i == wresp_pkg::id_t'(g));
    assign fill_hit = in_hs & (in_id == wresp_pkg::id_t'(g));
    assign load_hit = load & (pick_id_i == wresp_pkg::id_t'(g));
    // Nothing left in the list once this cycle's load is taken
    assign drains   = (res_cnt_q == '0) & (fill_cnt_q == cnt_t'(load_hit));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        res_tail_q  <= '0;
        fill_head_q <= '0;
        tail_q      <= '0;
        res_cnt_q   <= '0;
        fill_cnt_q  <= '0;
      end else begin
        if (res_hit) begin
          res_tail_q <= free_addr_i;
        end
        // New slot is the fill head when no other reserved slot remains
        if (res_hit && ((res_cnt_q == '0) || ((res_cnt_q == cnt_t'(1)) && fill_hit))) begin
          fill_head_q <= free_addr_i;
        end else if (fill_hit) begin
          fill_head_q <= link.link_rdata_a;
        end
        if (res_hit && drains) begin
          tail_q <= free_addr_i;
        end else if (load_hit) begin
          tail_q <= link.link_rdata_b;
        end
        res_cnt_q  <= res_cnt_q + cnt_t'(res_hit) - cnt_t'(fill_hit);
        fill_cnt_q <= fill_cnt_q + cnt_t'(fill_hit) - cnt_t'(load_hit);
      end
    end

    assign res_tails[g]    = res_tail_q;
    assign fill_heads[g]   = fill_head_q;
    assign tails_o[g]      = tail_q;
    assign has_reserved[g] = (res_cnt_q != '0);
    assign nonempty_o[g]   = (fill_cnt_q != '0);
    assign list_empty[g]   = (res_cnt_q == '0) & (fill_cnt_q == '0);
  end

  // One-entry output register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      out_valid_q <= 1'b1;
    end else if (out_hs) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_data_q <= link.msg_rdata;
      out_addr_q <= pick_addr_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

  // Slot is released at the output handshake
  assign free_onehot_o = out_hs ? (wresp_pkg::slot_vec_t'(1) << out_addr_q) : '0;

endmodule

`default_nettype wire

// ==== design/wresp_release_pick.sv ====
// Picks the lowest identifier whose oldest message is release-enabled
// Tails of identifiers without stored messages are ignored
`timescale 1ns/100ps
`default_nettype none

`include "wresp_config.svh"

module wresp_release_pick (
  input  wresp_pkg::slot_addr_t [`WRESP_NUM_IDS-1:0] tails_i,
  input  wresp_pkg::id_vec_t                         nonempty_i,
  input  wresp_pkg::slot_vec_t                       release_en_i,
  output logic                                       pick_valid_o,
  output wresp_pkg::id_t                             pick_id_o,
  output wresp_pkg::slot_addr_t                      pick_addr_o
);

  wresp_pkg::id_vec_t eligible;

  for (genvar g = 0; g < `WRESP_NUM_IDS; g++) begin : g_elig
    assign eligible[g] = nonempty_i[g] & release_en_i[tails_i[g]];
  end

  assign pick_valid_o = |eligible;

  // Scan downwards so the lowest eligible identifier is kept
  always_comb begin
    pick_id_o = '0;
    for (int i = `WRESP_NUM_IDS - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        pick_id_o = wresp_pkg::id_t'(i);
      end
    end
  end

  assign pick_addr_o = tails_i[pick_id_o];

endmodule

`default_nettype wire

// ==== design/wresp_msg_store.sv ====
// Flop-based message and link arrays, combinational reads
// Read data reflects the array before this cycle's writes
`timescale 1ns/100ps
`default_nettype none

`include "wresp_config.svh"

module wresp_msg_store (
  input  logic        clk_i,
  input  logic        rst_ni,
  wresp_link_if.store link
);

  logic [`WRESP_MSG_W-1:0]                      msg_mem [`WRESP_CAPACITY];
  wresp_pkg::slot_addr_t [`WRESP_CAPACITY-1:0]  link_q;

  // Messages are held as raw words
  always_ff @(posedge clk_i) begin
    if (link.msg_we) begin
      msg_mem[link.msg_waddr] <= link.msg_wdata.raw;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      link_q <= '0;
    end else if (link.link_we) begin
      link_q[link.link_waddr] <= link.link_wdata;
    end
  end

  assign link.msg_rdata.raw = msg_mem[link.msg_raddr];

  // Next slot after the fill head and after the tail
  assign link.link_rdata_a  = link_q[link.link_raddr_a];
  assign link.link_rdata_b  = link_q[link.link_raddr_b];

endmodule

`default_nettype wire

// ==== design/wresp_slot_alloc.sv ====
// Slot occupancy and lowest-free-slot search
// Occupy and free never target the same slot in one cycle
`timescale 1ns/100ps
`default_nettype none

`include "wresp_config.svh"

module wresp_slot_alloc (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  occupy_i,
  input  wresp_pkg::slot_addr_t occupy_addr_i,
  input  wresp_pkg::slot_vec_t  free_onehot_i,
  output wresp_pkg::slot_addr_t free_addr_o,
  output logic                  any_free_o
);

  wresp_pkg::slot_vec_t occ_q;
  wresp_pkg::slot_vec_t occ_set;

  assign occ_set = occupy_i ? (wresp_pkg::slot_vec_t'(1) << occupy_addr_i) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= (occ_q | occ_set) & ~free_onehot_i;
    end
  end

  assign any_free_o = ~&occ_q;

  // Priority encoder, lowest clear bit wins
  always_comb begin
    free_addr_o = '0;
    for (int a = `WRESP_CAPACITY - 1; a >= 0; a--) begin
      if (!occ_q[a]) begin
        free_addr_o = wresp_pkg::slot_addr_t'(a);
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/wresp_link_if.sv ====
// Storage and link-array access between controller and store
// Reads are combinational, writes land at the clock edge
`timescale 1ns/100ps
`default_nettype none

interface wresp_link_if;

  // Message array
  logic                  msg_we;
  wresp_pkg::slot_addr_t msg_waddr;
  wresp_pkg::msg_u       msg_wdata;
  wresp_pkg::slot_addr_t msg_raddr;
  wresp_pkg::msg_u       msg_rdata;

  // Next-slot link array, port a follows fill heads, port b follows tails
  logic                  link_we;
  wresp_pkg::slot_addr_t link_waddr;
  wresp_pkg::slot_addr_t link_wdata;
  wresp_pkg::slot_addr_t link_raddr_a;
  wresp_pkg::slot_addr_t link_rdata_a;
  wresp_pkg::slot_addr_t link_raddr_b;
  wresp_pkg::slot_addr_t link_rdata_b;

  modport ctrl (
    output msg_we, msg_waddr, msg_wdata, msg_raddr,
    output link_we, link_waddr, link_wdata, link_raddr_a, link_raddr_b,
    input  msg_rdata, link_rdata_a, link_rdata_b
  );

  modport store (
    input  msg_we, msg_waddr, msg_wdata, msg_raddr,
    input  link_we, link_waddr, link_wdata, link_raddr_a, link_raddr_b,
    output msg_rdata, link_rdata_a, link_rdata_b
  );

endinterface

`default_nettype wire

// ==== design/wresp_pkg.sv ====
// Shared types for the write-response bank, sized by the config macros
`default_nettype none

`include "wresp_config.svh"

package wresp_pkg;

  typedef logic [`WRESP_ADDR_W-1:0] slot_addr_t;
  typedef logic [`WRESP_ID_W-1:0] id_t;

  // One bit per slot or per identifier
  typedef logic [`WRESP_CAPACITY-1:0] slot_vec_t;
  typedef logic [`WRESP_NUM_IDS-1:0] id_vec_t;

  // Payload above, identifier in the low bits
  typedef struct packed {
    logic [`WRESP_MSG_W-`WRESP_ID_W-1:0] payload;
    id_t                                 id;
  } msg_fields_t;

  typedef union packed {
    logic [`WRESP_MSG_W-1:0] raw;
    msg_fields_t             f;
  } msg_u;

endpackage

`default_nettype wire

// ==== design/wresp_config.svh ====
// Build-time sizes for the write-response bank; capacity must be a power of two
// Identifier field sits in the low bits of every message
`ifndef WRESP_CONFIG_SVH
`define WRESP_CONFIG_SVH

`define WRESP_MSG_W 32
`define WRESP_ID_W 4
`define WRESP_NUM_IDS (1 << `WRESP_ID_W)
`define WRESP_CAPACITY 16
// Slot address width, log2 of the capacity
`define WRESP_ADDR_W $clog2(`WRESP_CAPACITY)

`endif
